// ==== vlog.f ====
+incdir+rtl
rtl/rcn_pkg.sv
rtl/rcn_master.sv
rtl/rcn_slave_ram.sv
rtl/rcn_ram.sv
rtl/rcn_ring_top.sv
verification/tb_rcn_ring.sv

// ==== Makefile ====
# Verilator build and run of the RCN ring testbench

TOP := tb_rcn_ring

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// ==== verification/tb_rcn_ring.sv ====
/*
 * Self-checking testbench for the RCN ring top level.
 * Issues directed and random host commands, predicts each response from
 * a model of both RAM windows and compares it when rsp_valid pulses.
 */
`timescale 1ns/100ps
`include "rcn_cfg.svh"

module tb_rcn_ring;
  import rcn_pkg::*;

  localparam int DEPTH          = 2 ** `RCN_RAM_AW;
  localparam int DIRECTED_TXN   = 17;
  localparam int INIT_TXN       = 32;
  localparam int RANDOM_TXN     = 200;
  localparam int NUM_TXN        = DIRECTED_TXN + INIT_TXN + RANDOM_TXN;
  localparam int TIMEOUT_CYCLES = NUM_TXN * 20 + 100;
  // Bound on a single wait for busy or for a response
  localparam int WAIT_LIMIT     = 40;

  logic     CLK;
  logic     RST;
  logic     cmd_valid;
  rcn_cmd_t cmd;
  logic     busy;
  logic     rsp_valid;
  rcn_rsp_t rsp;

  // Model of both RAMs, with a flag per word once its contents are defined
  logic [31:0] model0 [DEPTH];
  logic [31:0] model1 [DEPTH];
  bit          known0 [DEPTH];
  bit          known1 [DEPTH];

  // Expected responses in issue order, and whether their data can be checked
  rcn_rsp_t exp_q [$];
  bit       data_chk_q [$];

  int     rsp_count   = 0;
  int     cycle_count = 0;
  integer seed;

  rcn_ring_top dut (
    .CLK       (CLK),
    .RST       (RST),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .busy      (busy),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  initial CLK = 1'b0;
  always #4 CLK = ~CLK;

  task automatic end_with_failure();
    $display("*** FAILED ***");
    $fatal(1, "Run stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      end_with_failure();
    end
  endtask

  // Returns 0 for the RAM0 window, 1 for RAM1, and 2 when nothing claims it
  function automatic int window_of(logic [17:0] addr);
    logic [19:0] byte_addr;
    byte_addr = {addr, 2'b00};
    if ((byte_addr & `RCN_ADDR_MASK) == (`RCN_RAM0_BASE & `RCN_ADDR_MASK))
    begin
      return 0;
    end
    if ((byte_addr & `RCN_ADDR_MASK) == (`RCN_RAM1_BASE & `RCN_ADDR_MASK))
    begin
      return 1;
    end
    return 2;
  endfunction

  // True when the old word the response carries has a defined value
  function automatic bit data_known(rcn_cmd_t c);
    int idx;
    idx = int'(c.addr) % DEPTH;
    case (window_of(c.addr))
      0:       return known0[idx];
      1:       return known1[idx];
      default: return 1'b1;
    endcase
  endfunction

  // Reference model of read-first access with byte-masked update and index aliasing
  function automatic rcn_rsp_t rcn_expect(rcn_cmd_t c);
    rcn_rsp_t    r;
    int          win;
    int          idx;
    logic [31:0] old_word;
    logic [31:0] new_word;
    win = window_of(c.addr);
    idx = int'(c.addr) % DEPTH;
    old_word = 32'd0;
    if (win == 0)
    begin
      old_word = model0[idx];
    end
    else if (win == 1)
    begin
      old_word = model1[idx];
    end
    new_word = old_word;
    for (int b = 0; b < 4; b++)
    begin
      if (c.mask[b])
      begin
        new_word[8*b +: 8] = c.data[8*b +: 8];
      end
    end
    // Only a full-mask write makes an undefined word fully defined
    if (win == 0)
    begin
      model0[idx] = new_word;
      known0[idx] = known0[idx] || (c.mask == 4'hF);
    end
    else if (win == 1)
    begin
      model1[idx] = new_word;
      known1[idx] = known1[idx] || (c.mask == 4'hF);
    end
    r.err  = (win == 2);
    r.data = (win == 2) ? 32'd0 : old_word;
    return r;
  endfunction

  // Picks a random address in RAM0, RAM1 or unmapped space over a pool of 16 words
  // The top offset bits vary so that aliased addresses are hit as well
  function automatic logic [17:0] random_addr(logic [31:0] r);
    logic [3:0] region;
    region = r[13:10];
    if (r[1:0] == 2'd0)
    begin
      region = 4'h1;
    end
    else if (r[1:0] == 2'd1)
    begin
      region = 4'h2;
    end
    else if (region == 4'h1 || region == 4'h2)
    begin
      region = 4'h5;
    end
    return {region, r[9:6], 6'h10, r[5:2]};
  endfunction

  // Issues one command once busy is low and waits for its response
  task automatic run_cmd(input logic [3:0] mask, input logic [17:0] addr,
                         input logic [31:0] data);
    rcn_cmd_t c;
    int       wait_cycles;
    int       count_before;
    c.mask = mask;
    c.addr = addr;
    c.data = data;
    wait_cycles = 0;
    @(negedge CLK);
    while (busy)
    begin
      if (wait_cycles >= WAIT_LIMIT)
      begin
        $display("Busy stayed high long after the last response");
        end_with_failure();
      end
      else
      begin
        wait_cycles++;
        @(negedge CLK);
      end
    end
    data_chk_q.push_back(data_known(c));
    exp_q.push_back(rcn_expect(c));
    count_before = rsp_count;
    @(posedge CLK);
    cmd_valid <= 1'b1;
    cmd       <= c;
    @(posedge CLK);
    cmd_valid <= 1'b0;
    // Busy rises in the cycle after the command is taken
    @(negedge CLK);
    check_value("busy", {31'd0, busy}, 32'd1);
    wait_cycles = 0;
    while (rsp_count == count_before)
    begin
      if (wait_cycles >= WAIT_LIMIT)
      begin
        $display("No response arrived for the command to word address 0x%h", addr);
        end_with_failure();
      end
      else
      begin
        wait_cycles++;
        @(posedge CLK);
      end
    end
  endtask

  // Compares every response pulse with the oldest expected response
  initial
  begin : compare_proc
    rcn_rsp_t exp_rsp;
    bit       chk;
    forever
    begin
      @(negedge CLK);
      if (!RST && rsp_valid)
      begin
        if (exp_q.size() == 0)
        begin
          $display("A response arrived while no command was outstanding");
          end_with_failure();
        end
        else
        begin
          exp_rsp = exp_q.pop_front();
          chk     = data_chk_q.pop_front();
          // Busy still covers the cycle of the response
          check_value("busy", {31'd0, busy}, 32'd1);
          check_value("rsp.err", {31'd0, rsp.err}, {31'd0, exp_rsp.err});
          if (chk)
          begin
            check_value("rsp.data", rsp.data, exp_rsp.data);
          end
          rsp_count++;
        end
      end
    end
  end

  always @(posedge CLK)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles before all tests finished", cycle_count);
      end_with_failure();
    end
  end

  initial
  begin : stimulus
    logic [31:0] r;
    logic [31:0] r2;
    seed      = 32'h55502d48;
    RST       <= 1'b1;
    cmd_valid <= 1'b0;
    cmd       <= '0;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;

    // The DUT stays quiet after reset and the compare process flags any stray pulse
    @(negedge CLK);
    check_value("busy", {31'd0, busy}, 32'd0);
    check_value("rsp_valid", {31'd0, rsp_valid}, 32'd0);
    repeat (10) @(posedge CLK);

    // In RAM0 the second write returns the first word and the read sees the second
    $display("Test 2: write and read back in RAM0");
    run_cmd(4'hF, 18'h04010, 32'h11111111);
    run_cmd(4'hF, 18'h04010, 32'hA5A55A5A);
    run_cmd(4'h0, 18'h04010, 32'h0);

    // Byte masks only touch their own lanes
    $display("Test 3: partial writes");
    run_cmd(4'b0001, 18'h04010, 32'hFFFFFF01);
    run_cmd(4'b0110, 18'h04010, 32'h00BEEF00);
    run_cmd(4'b1000, 18'h04010, 32'h77000000);
    run_cmd(4'h0, 18'h04010, 32'h0);

    // Windows are independent and indices above the depth alias
    $display("Test 4: separate RAMs and aliasing");
    run_cmd(4'hF, 18'h08010, 32'h22223333);
    run_cmd(4'h0, 18'h08010, 32'h0);
    run_cmd(4'h0, 18'h04010, 32'h0);
    run_cmd(4'h0, 18'h04410, 32'h0);
    run_cmd(4'hF, 18'h08810, 32'h44445555);
    run_cmd(4'h0, 18'h08010, 32'h0);

    // Byte address 0x50040 belongs to no slave and shares its RAM index with the
    // words read back right after it
    $display("Test 5: unmapped address");
    run_cmd(4'h0, 18'h14010, 32'h0);
    run_cmd(4'hF, 18'h14010, 32'hDEADBEEF);
    run_cmd(4'h0, 18'h04010, 32'h0);
    run_cmd(4'h0, 18'h08010, 32'h0);

    // The random pool is defined in both RAMs before random traffic starts
    $display("Test 6: random commands");
    for (int i = 0; i < INIT_TXN / 2; i++)
    begin
      run_cmd(4'hF, 18'h04100 + 18'(i), $random(seed));
      run_cmd(4'hF, 18'h08100 + 18'(i), $random(seed));
    end
    for (int i = 0; i < RANDOM_TXN; i++)
    begin
      r  = $random(seed);
      r2 = $random(seed);
      run_cmd(r[17:14], random_addr(r), r2);
    end

    repeat (5) @(posedge CLK);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== rtl/rcn_ring_top.sv ====
/*
 * Top level of the RCN ring.
 * The loop runs master, slave 0, slave 1 and back to the master,
 * and each slave owns one RAM.
 */
`timescale 1ns/100ps
`include "rcn_cfg.svh"

module rcn_ring_top
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              cmd_valid,
  input  rcn_pkg::rcn_cmd_t cmd,
  output logic              busy,
  output logic              rsp_valid,
  output rcn_pkg::rcn_rsp_t rsp
);
  import rcn_pkg::*;

  // Ring links, each driven by exactly one node
  rcn_word_t   ring_m2s0;
  rcn_word_t   ring_s02s1;
  rcn_word_t   ring_s12m;

  // RAM port of slave 0
  logic        ram0_cs;
  logic        ram0_we;
  logic [17:0] ram0_index;
  logic [3:0]  ram0_byte_en;
  logic [31:0] ram0_wdata;
  logic [31:0] ram0_rdata;

  // RAM port of slave 1
  logic        ram1_cs;
  logic        ram1_we;
  logic [17:0] ram1_index;
  logic [3:0]  ram1_byte_en;
  logic [31:0] ram1_wdata;
  logic [31:0] ram1_rdata;

  rcn_master #(
    .MASTER_ID (`RCN_MASTER_ID)
  ) u_master (
    .CLK       (CLK),
    .RST       (RST),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .ring_in   (ring_s12m),
    .ring_out  (ring_m2s0),
    .busy      (busy),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  // First slave on the ring serves the low window
  rcn_slave_ram #(
    .ADDR_BASE (`RCN_RAM0_BASE),
    .ADDR_MASK (`RCN_ADDR_MASK)
  ) u_slave0 (
    .CLK      (CLK),
    .RST      (RST),
    .ring_in  (ring_m2s0),
    .ring_out (ring_s02s1),
    .cs       (ram0_cs),
    .we       (ram0_we),
    .index    (ram0_index),
    .byte_en  (ram0_byte_en),
    .wdata    (ram0_wdata),
    .rdata    (ram0_rdata)
  );

  rcn_slave_ram #(
    .ADDR_BASE (`RCN_RAM1_BASE),
    .ADDR_MASK (`RCN_ADDR_MASK)
  ) u_slave1 (
    .CLK      (CLK),
    .RST      (RST),
    .ring_in  (ring_s02s1),
    .ring_out (ring_s12m),
    .cs       (ram1_cs),
    .we       (ram1_we),
    .index    (ram1_index),
    .byte_en  (ram1_byte_en),
    .wdata    (ram1_wdata),
    .rdata    (ram1_rdata)
  );

  rcn_ram #(
    .AW (`RCN_RAM_AW)
  ) u_ram0 (
    .CLK     (CLK),
    .cs      (ram0_cs),
    .we      (ram0_we),
    .index   (ram0_index),
    .byte_en (ram0_byte_en),
    .wdata   (ram0_wdata),
    .rdata   (ram0_rdata)
  );

  rcn_ram #(
    .AW (`RCN_RAM_AW)
  ) u_ram1 (
    .CLK     (CLK),
    .cs      (ram1_cs),
    .we      (ram1_we),
    .index   (ram1_index),
    .byte_en (ram1_byte_en),
    .wdata   (ram1_wdata),
    .rdata   (ram1_rdata)
  );

endmodule

// ==== rtl/rcn_ram.sv ====
/*
 * Synchronous single-port word RAM with byte write enables.
 * Reads are read-first, so a write returns the old word on rdata.
 */
`timescale 1ns/100ps
`include "rcn_cfg.svh"

module rcn_ram
#(
  parameter int AW = `RCN_RAM_AW
)
(
  input  logic        CLK,
  input  logic        cs,
  input  logic        we,
  input  logic [17:0] index,
  input  logic [3:0]  byte_en,
  input  logic [31:0] wdata,
  output logic [31:0] rdata
);

  logic [31:0]   mem [2**AW];

  // Upper index bits are ignored, so addresses above the depth alias
  logic [AW-1:0] word_sel;

  assign word_sel = index[AW-1:0];

  always_ff @(posedge CLK)
  begin
    if (cs)
    begin
      // Old contents are captured before the write takes effect
      rdata <= mem[word_sel];
      if (we)
      begin
        for (int b = 0; b < 4; b++)
        begin
          if (byte_en[b])
          begin
            mem[word_sel][8*b +: 8] <= wdata[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

// ==== rtl/rcn_slave_ram.sv ====
/*
 * RCN ring slave in front of a word RAM.
 * Requests inside the window become RAM accesses and leave as responses
 * two cycles later, all other words pass with the same delay.
 */
`timescale 1ns/100ps
`include "rcn_cfg.svh"

module rcn_slave_ram
#(
  parameter logic [19:0] ADDR_BASE = `RCN_RAM0_BASE,
  parameter logic [19:0] ADDR_MASK = `RCN_ADDR_MASK
)
(
  input  logic               CLK,
  input  logic               RST,
  input  rcn_pkg::rcn_word_t ring_in,
  output rcn_pkg::rcn_word_t ring_out,
  output logic               cs,
  output logic               we,
  output logic [17:0]        index,
  output logic [3:0]         byte_en,
  output logic [31:0]        wdata,
  input  logic [31:0]        rdata
);
  import rcn_pkg::*;

  // First stage holds the word while the RAM is addressed
  rcn_word_t din;
  // Second stage lines up with the RAM read data
  rcn_word_t din_d1;
  logic      hit_d1;
  logic      addr_hit;

  // Valid request whose byte address falls in this window
  assign addr_hit = din.valid && din.req &&
                    (({din.addr, 2'b00} & ADDR_MASK) == (ADDR_BASE & ADDR_MASK));

  // RAM port straight from the first stage
  assign cs      = addr_hit;
  assign we      = |din.mask;
  assign index   = din.addr;
  assign byte_en = din.mask;
  assign wdata   = din.data;

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      din    <= '0;
      din_d1 <= '0;
      hit_d1 <= 1'b0;
    end
    else
    begin
      din    <= ring_in;
      din_d1 <= din;
      hit_d1 <= addr_hit;
    end
  end

  // A hit turns into a response carrying the old RAM word
  // Header, mask and address go out as they came in
  always_comb
  begin
    ring_out = din_d1;
    if (hit_d1)
    begin
      ring_out.req  = 1'b0;
      ring_out.data = rdata;
    end
  end

endmodule

// ==== rtl/rcn_master.sv ====
/*
 * Single host master on the RCN ring.
 * Takes one command at a time, injects it into a free slot and
 * retires the matching word when it comes back around the loop.
 */
`timescale 1ns/100ps
`include "rcn_cfg.svh"

module rcn_master
#(
  parameter logic [5:0] MASTER_ID = `RCN_MASTER_ID
)
(
  input  logic               CLK,
  input  logic               RST,
  input  logic               cmd_valid,
  input  rcn_pkg::rcn_cmd_t  cmd,
  input  rcn_pkg::rcn_word_t ring_in,
  output rcn_pkg::rcn_word_t ring_out,
  output logic               busy,
  output logic               rsp_valid,
  output rcn_pkg::rcn_rsp_t  rsp
);
  import rcn_pkg::*;

  // Command held while it waits for a slot and travels the ring
  rcn_cmd_t   cmd_q;
  rcn_word_t  req_word;

  // Pending means taken but not yet on the ring
  logic       pending;
  // Inflight means injected and not yet returned
  logic       inflight;
  logic [1:0] seq;

  logic       cmd_take;
  logic       inject;
  logic       own_word;
  logic       ret_hit;

  // Host strobes are ignored while a transaction is open
  assign cmd_take = cmd_valid && !busy;

  // Only an empty incoming slot may be replaced by a new request
  assign inject = pending && !ring_in.valid;

  // Any word carrying this id is taken off the ring
  assign own_word = ring_in.valid && (ring_in.src_id == MASTER_ID);

  // Only the current tag ends the open transaction, a stale tag is dropped silently
  assign ret_hit = own_word && inflight && (ring_in.seq == seq);

  // Request word built from the held command
  always_comb
  begin
    req_word.valid  = 1'b1;
    req_word.req    = 1'b1;
    req_word.src_id = MASTER_ID;
    req_word.seq    = seq;
    req_word.mask   = cmd_q.mask;
    req_word.addr   = cmd_q.addr;
    req_word.data   = cmd_q.data;
  end

  // Control state and the outgoing ring register
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      pending   <= 1'b0;
      inflight  <= 1'b0;
      seq       <= 2'd0;
      busy      <= 1'b0;
      rsp_valid <= 1'b0;
      ring_out  <= '0;
    end
    else
    begin
      rsp_valid <= ret_hit;

      // Busy rises the cycle after the take and falls after the response pulse
      if (cmd_take)
      begin
        busy <= 1'b1;
      end
      else if (rsp_valid)
      begin
        busy <= 1'b0;
      end

      if (cmd_take)
      begin
        pending <= 1'b1;
      end
      else if (inject)
      begin
        pending <= 1'b0;
      end

      if (inject)
      begin
        inflight <= 1'b1;
      end
      else if (ret_hit)
      begin
        inflight <= 1'b0;
      end

      // The next command gets a fresh tag
      if (ret_hit)
      begin
        seq <= seq + 2'd1;
      end

      // Own words leave an empty slot behind
      // Foreign traffic is forwarded as it arrived
      if (own_word)
      begin
        ring_out <= '0;
      end
      else if (inject)
      begin
        ring_out <= req_word;
      end
      else
      begin
        ring_out <= ring_in;
      end
    end
  end

  // Payload registers for the command and the response
  always_ff @(posedge CLK)
  begin
    if (cmd_take)
    begin
      cmd_q <= cmd;
    end

    // A word that comes back still marked as a request found no slave
    if (ret_hit)
    begin
      rsp.err  <= ring_in.req;
      rsp.data <= ring_in.req ? 32'd0 : ring_in.data;
    end
  end

endmodule

// ==== rtl/rcn_pkg.sv ====
/*
 * Types shared by the RCN ring master, slaves and top level.
 * One struct describes both request and response words on the ring.
 */
package rcn_pkg;

  // One 64-bit slot on the ring
  // Requests and responses keep the same field layout
  typedef struct packed {
    logic        valid;
    logic        req;
    logic [5:0]  src_id;
    logic [1:0]  seq;
    // Nonzero byte enables mark a write
    logic [3:0]  mask;
    // Word address, the byte address has two zero bits appended
    logic [17:0] addr;
    logic [31:0] data;
  } rcn_word_t;

  // Host command, a zero mask is a read
  typedef struct packed {
    logic [3:0]  mask;
    logic [17:0] addr;
    logic [31:0] data;
  } rcn_cmd_t;

  // Host response
  // Err is set when no slave claimed the request
  typedef struct packed {
    logic        err;
    logic [31:0] data;
  } rcn_rsp_t;

endpackage

// ==== rtl/rcn_cfg.svh ====
/*
 * Build-time constants for the RCN ring subsystem.
 * Include this where a master id, an address window or a RAM size is needed.
 */
`ifndef RCN_CFG_SVH
`define RCN_CFG_SVH

// Ring id of the single host master
`define RCN_MASTER_ID 6'd1

// Window mask applied to the 20-bit byte address
`define RCN_ADDR_MASK 20'hF0000

// Window bases of the two RAM slaves
`define RCN_RAM0_BASE 20'h10000
`define RCN_RAM1_BASE 20'h20000

// Word index width of each RAM, which gives 1024 words
`define RCN_RAM_AW 10

`endif
